// ==== Makefile ====
# Verilator simulation of the framebuffer subsystem

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal \
		--top-module tb_framebuffer_bram -f framebuffer_bram.f \
		--Mdir obj_dir -o sim_tb
	@out="$$(./obj_dir/sim_tb)"; echo "$$out"; \
		echo "$$out" | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir

// ==== common/fb_pkg.sv ====
// framebuffer package
// buffer geometry, data widths and the scan sequencer state type

`default_nettype none

package fb_pkg;

    // framebuffer geometry
    localparam logic [15:0] fb_width = 16'd16;  // pixels per line
    localparam int fb_height = 12;               // lines per buffer
    localparam int fb_pixels = fb_width * fb_height;  // 192 entries
    localparam int fb_addrw = 8;                 // covers fb_pixels

    // coordinate and colour widths
    localparam int cordw = 16;  // signed drawing coordinates
    localparam int cidxw = 4;   // colour index, 16 colours
    localparam int chanw = 4;   // bits per colour channel

    // display scaling, same factor horizontally and vertically
    localparam int lb_scale = 2;

    // min cycles from line strobe to de rising
    // scan reads fb_width pixels plus 3 pipeline cycles inside this window
    localparam int lb_fill_cycles = 24;

    // palette image, one 3-digit hex rgb word per line
    localparam string palette_file = "palette.mem";

    // scan sequencer state
    typedef enum logic {
        scan_idle,  // waiting for line request
        scan_fill   // streaming one row out of the buffer
    } scan_state_t;

endpackage

`default_nettype wire

// ==== framebuffer_bram.f ====
common/fb_pkg.sv
hdl/fb_draw_port.sv
hdl/fb_scanout.sv
hdl/bram_sdp.sv
hdl/clut_rom.sv
linebuffer/linebuffer.sv
hdl/framebuffer_bram.sv
test/tb_framebuffer_bram.sv

// ==== hdl/bram_sdp.sv ====
// simple dual-port block ram holding the colour index framebuffer
// one write port, one read port with a registered output

`timescale 1ns/1ps
`default_nettype none

module bram_sdp (
    input  wire logic                          clk_sys,
    input  wire logic                          wr_en,
    input  wire logic [fb_pkg::fb_addrw-1:0]   wr_addr,
    input  wire logic [fb_pkg::fb_addrw-1:0]   rd_addr,
    input  wire logic [fb_pkg::cidxw-1:0]      wr_data,
    output logic      [fb_pkg::cidxw-1:0]      rd_data
);
    import fb_pkg::*;

    logic [cidxw-1:0] mem [fb_pixels];  // contents undefined until drawn

    // write port
    always_ff @(posedge clk_sys) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // read port, 1 cycle latency
    always_ff @(posedge clk_sys) begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

// ==== hdl/clut_rom.sv ====
// colour lookup table
// maps a colour index to packed 4-bit red, green, blue through an output register

`timescale 1ns/1ps
`default_nettype none

module clut_rom (
    input  wire logic                            clk_sys,
    input  wire logic [fb_pkg::cidxw-1:0]        cidx,
    output logic      [3*fb_pkg::chanw-1:0]      colr  // {red, green, blue}
);
    import fb_pkg::*;

    logic [3*chanw-1:0] palette [2**cidxw];  // one entry per index

    // palette image loaded at elaboration
    initial begin
        $readmemh(palette_file, palette);
    end

    // registered lookup
    always_ff @(posedge clk_sys) begin
        colr <= palette[cidx];
    end

endmodule

`default_nettype wire

// ==== hdl/fb_draw_port.sv ====
// framebuffer drawing port
// turns signed x/y coordinates into a buffer address, clips and gates the write

`timescale 1ns/1ps
`default_nettype none

module fb_draw_port (
    input  wire logic                             clk_sys,
    input  wire logic                             rst_sys,
    input  wire logic                             we,       // draw strobe
    input  wire logic signed [fb_pkg::cordw-1:0]  x,
    input  wire logic signed [fb_pkg::cordw-1:0]  y,
    input  wire logic        [fb_pkg::cidxw-1:0]  cidx,
    output logic                                  clip,     // write fell outside buffer
    output logic                                  wr_en,
    output logic             [fb_pkg::fb_addrw-1:0] wr_addr,
    output logic             [fb_pkg::cidxw-1:0]  wr_data
);
    import fb_pkg::*;

    logic                out_of_range;  // coordinate outside buffer
    logic [fb_addrw-1:0] row_base;      // stage 1: y * width
    logic [fb_addrw-1:0] x_s1;          // stage 1: column
    logic [cidxw-1:0]    cidx_s1;       // stage 1: colour
    logic                we_s1;         // stage 1: strobe

    always_comb begin
        out_of_range = (x < 0) || (x >= $signed(fb_width)) ||
                       (y < 0) || (y >= fb_height);
    end

    // stage 1: row multiply and bounds check
    always_ff @(posedge clk_sys) begin
        row_base <= fb_addrw'(y * fb_width);  // low bits only
        x_s1     <= x[fb_addrw-1:0];
        cidx_s1  <= cidx;
        if (rst_sys) begin
            we_s1 <= 1'b0;
            clip  <= 1'b0;
        end else begin
            we_s1 <= we;
            clip  <= we && out_of_range;  // only flag real writes
        end
    end

    // stage 2: add column, drop clipped writes
    always_ff @(posedge clk_sys) begin
        wr_addr <= row_base + x_s1;
        wr_data <= cidx_s1;
        if (rst_sys) begin
            wr_en <= 1'b0;
        end else begin
            wr_en <= we_s1 && !clip;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/fb_scanout.sv ====
// framebuffer scan sequencer
// reads one buffer row per line request, one address per cycle,
// and rewinds to row 0 at each frame

`timescale 1ns/1ps
`default_nettype none

module fb_scanout (
    input  wire logic                          clk_sys,
    input  wire logic                          rst_sys,
    input  wire logic                          frame,     // rewind to row 0
    input  wire logic                          line_req,  // fetch next row
    output logic [fb_pkg::fb_addrw-1:0]        rd_addr,
    output logic                               rd_valid   // read issued this cycle
);
    import fb_pkg::*;

    scan_state_t                 state;
    logic [$clog2(fb_width)-1:0] pix_cnt;   // column within row
    logic [fb_addrw-1:0]         row_base;  // first address of current row
    logic                        last_pix;

    always_comb begin
        last_pix = (pix_cnt == $bits(pix_cnt)'(fb_width - 1));
    end

    // state, column and row tracking
    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            state    <= scan_idle;
            pix_cnt  <= '0;
            row_base <= '0;
        end else begin
            case (state)
                scan_idle: begin
                    if (line_req) begin  // start row on next cycle
                        state   <= scan_fill;
                        pix_cnt <= '0;
                    end
                end
                scan_fill: begin  // requests here are dropped
                    if (last_pix) begin
                        state    <= scan_idle;
                        row_base <= row_base + fb_addrw'(fb_width);  // next row
                    end else begin
                        pix_cnt <= pix_cnt + 1'b1;
                    end
                end
                default: begin
                    state <= scan_idle;
                end
            endcase

            // new frame wins over any row in progress
            if (frame) begin
                state    <= scan_idle;
                row_base <= '0;
            end
        end
    end

    // address follows column count directly
    always_comb begin
        rd_addr  = row_base + fb_addrw'(pix_cnt);
        rd_valid = (state == scan_fill);
    end

endmodule

`default_nettype wire

// ==== hdl/framebuffer_bram.sv ====
// indexed colour framebuffer in block ram
// draw port writes colour indices, scan side reads rows through the palette
// into a scaling line buffer for display

`timescale 1ns/1ps
`default_nettype none

module framebuffer_bram (
    input  wire logic                             clk_sys,
    input  wire logic                             rst_sys,
    input  wire logic                             we,     // draw strobe
    input  wire logic signed [fb_pkg::cordw-1:0]  x,
    input  wire logic signed [fb_pkg::cordw-1:0]  y,
    input  wire logic        [fb_pkg::cidxw-1:0]  cidx,
    input  wire logic                             frame,  // display timing
    input  wire logic                             line,
    input  wire logic                             de,
    output logic                                  clip,   // last write dropped
    output logic             [fb_pkg::chanw-1:0]  red,
    output logic             [fb_pkg::chanw-1:0]  green,
    output logic             [fb_pkg::chanw-1:0]  blue
);
    import fb_pkg::*;

    logic                wr_en;
    logic [fb_addrw-1:0] wr_addr;
    logic [cidxw-1:0]    wr_data;
    logic [fb_addrw-1:0] rd_addr;
    logic                rd_valid;
    logic [cidxw-1:0]    rd_data;
    logic [3*chanw-1:0]  clut_colr;
    logic [1:0]          rd_valid_dly;  // bram + clut latency
    logic                din_valid;
    logic                line_req;

    fb_draw_port u_fb_draw_port (
        .clk_sys (clk_sys),
        .rst_sys (rst_sys),
        .we      (we),
        .x       (x),
        .y       (y),
        .cidx    (cidx),
        .clip    (clip),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data)
    );

    fb_scanout u_fb_scanout (
        .clk_sys  (clk_sys),
        .rst_sys  (rst_sys),
        .frame    (frame),
        .line_req (line_req),
        .rd_addr  (rd_addr),
        .rd_valid (rd_valid)
    );

    bram_sdp u_bram_sdp (
        .clk_sys (clk_sys),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .rd_addr (rd_addr),
        .wr_data (wr_data),
        .rd_data (rd_data)
    );

    clut_rom u_clut_rom (
        .clk_sys (clk_sys),
        .cidx    (rd_data),    // index straight from bram
        .colr    (clut_colr)
    );

    // valid follows the data through bram and clut
    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            rd_valid_dly <= '0;
        end else begin
            rd_valid_dly <= {rd_valid_dly[0], rd_valid};
        end
    end

    always_comb begin
        din_valid = rd_valid_dly[1];
    end

    linebuffer u_linebuffer (
        .clk_sys   (clk_sys),
        .rst_sys   (rst_sys),
        .frame     (frame),
        .line      (line),
        .de        (de),
        .din_valid (din_valid),
        .din       (clut_colr),
        .line_req  (line_req),
        .red       (red),
        .green     (green),
        .blue      (blue)
    );

endmodule

`default_nettype wire

// ==== linebuffer/linebuffer.sv ====
// display line buffer
// stores one row of rgb colours and replays it scaled by lb_scale in x and y,
// blanking the output outside de

`timescale 1ns/1ps
`default_nettype none

module linebuffer (
    input  wire logic                          clk_sys,
    input  wire logic                          rst_sys,
    input  wire logic                          frame,      // start of frame
    input  wire logic                          line,       // start of display line
    input  wire logic                          de,         // visible part of line
    input  wire logic                          din_valid,
    input  wire logic [3*fb_pkg::chanw-1:0]    din,        // {red, green, blue}
    output logic                               line_req,   // need a new row
    output logic      [fb_pkg::chanw-1:0]      red,
    output logic      [fb_pkg::chanw-1:0]      green,
    output logic      [fb_pkg::chanw-1:0]      blue
);
    import fb_pkg::*;

    logic [3*chanw-1:0]           lb_mem [fb_width];  // one row of colours
    logic [$clog2(fb_width)-1:0]  wr_ptr;
    logic [$clog2(fb_width)-1:0]  rd_ptr;
    logic [$clog2(lb_scale)-1:0]  line_phase;  // display line within a scaled row
    logic [$clog2(lb_scale)-1:0]  rep_cnt;     // output cycle within a scaled pixel

    // new row on the first display line of each scaled group
    always_comb begin
        line_req = line && (line_phase == '0);
    end

    // vertical repeat count, cleared by frame
    always_ff @(posedge clk_sys) begin
        if (rst_sys || frame) begin
            line_phase <= '0;
        end else if (line) begin
            if (line_phase == $bits(line_phase)'(lb_scale - 1)) begin
                line_phase <= '0;
            end else begin
                line_phase <= line_phase + 1'b1;
            end
        end
    end

    // fill side
    always_ff @(posedge clk_sys) begin
        if (rst_sys || line_req) begin
            wr_ptr <= '0;  // row restarts at column 0
        end else if (din_valid) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (din_valid) begin
            lb_mem[wr_ptr] <= din;
        end
    end

    // replay side, horizontal repeat
    always_ff @(posedge clk_sys) begin
        if (rst_sys || !de) begin
            rd_ptr  <= '0;  // restart from column 0 at de rise
            rep_cnt <= '0;
        end else if (rep_cnt == $bits(rep_cnt)'(lb_scale - 1)) begin
            rep_cnt <= '0;
            rd_ptr  <= rd_ptr + 1'b1;
        end else begin
            rep_cnt <= rep_cnt + 1'b1;
        end
    end

    // registered output, zero when de was low
    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            {red, green, blue} <= '0;
        end else if (de) begin
            {red, green, blue} <= lb_mem[rd_ptr];
        end else begin
            {red, green, blue} <= '0;
        end
    end

endmodule

`default_nettype wire

// ==== palette.mem ====
// rgb palette, one word per index: red green blue nibbles
0F5
1E4
2D7
3C6
4B1
5A0
693
782
87D
96C
A5F
B4E
C39
D28
E1B
F0A

// ==== test/tb_framebuffer_bram.sv ====
// testbench for the indexed colour framebuffer
// draws random pixels, runs display frames and checks clip and rgb output cycle by cycle

`timescale 1ns/1ps
`default_nettype none

module tb_framebuffer_bram;

    localparam int clk_period   = 40;
    localparam int fb_cols      = 16;   // buffer width
    localparam int fb_rows      = 12;   // buffer height
    localparam int disp_lines   = 24;   // rows scaled by 2
    localparam int blank_cycles = 24;   // line strobe to de
    localparam int vis_cycles   = 32;   // columns scaled by 2
    localparam int gap_cycles   = 4;
    localparam int frame_cycles = 2 + disp_lines * (1 + blank_cycles + vis_cycles + gap_cycles);
    localparam int write_cycles = fb_cols * fb_rows + 64;  // draws, clips and idles
    localparam int watchdog_cycles = 2 * (2 * frame_cycles + write_cycles);

    logic               clk_sys;
    logic               rst_sys;
    logic               we;
    logic signed [15:0] x;
    logic signed [15:0] y;
    logic        [3:0]  cidx;
    logic               frame;
    logic               line;
    logic               de;
    logic               clip;
    logic        [3:0]  red;
    logic        [3:0]  green;
    logic        [3:0]  blue;

    logic [3:0] ref_mem [fb_cols*fb_rows];  // expected buffer contents
    logic       exp_clip;     // clip expected for the write driven now
    int         disp_line;    // display line being driven
    int         disp_col;     // visible column being driven
    logic       prev_de;      // driven values one cycle back
    logic       prev_clip;
    int         prev_line;
    int         prev_col;
    logic signed [15:0] prev_x;  // coordinates of the write under check
    logic signed [15:0] prev_y;
    logic       armed;        // checking on once reset is applied
    int         seed;
    string      test_name;

    framebuffer_bram u_framebuffer_bram (
        .clk_sys (clk_sys),
        .rst_sys (rst_sys),
        .we      (we),
        .x       (x),
        .y       (y),
        .cidx    (cidx),
        .frame   (frame),
        .line    (line),
        .de      (de),
        .clip    (clip),
        .red     (red),
        .green   (green),
        .blue    (blue)
    );

    always #(clk_period/2) clk_sys = ~clk_sys;

    // red is i, green is 15 - i and blue is i xor 5
    function automatic logic [11:0] palette_rgb(input logic [3:0] i);
        return {i, 4'd15 - i, i ^ 4'd5};
    endfunction

    task automatic abort_run();
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk_sys);
            we       <= 1'b0;
            exp_clip <= 1'b0;
        end
    endtask

    // one draw strobe with the reference updated only for in-range writes
    task automatic draw_pixel(input int px, input int py, input logic [3:0] ci);
        logic outside;
        outside = (px < 0) || (px >= fb_cols) || (py < 0) || (py >= fb_rows);
        @(posedge clk_sys);
        we       <= 1'b1;
        x        <= 16'(px);
        y        <= 16'(py);
        cidx     <= ci;
        exp_clip <= outside;
        if (!outside) begin
            ref_mem[py*fb_cols + px] = ci;
        end
    endtask

    // frame strobe followed by line strobe, blank, de and gap per display line
    task automatic run_frame();
        int n;
        int c;
        @(posedge clk_sys);
        frame <= 1'b1;
        @(posedge clk_sys);
        frame <= 1'b0;
        for (n = 0; n < disp_lines; n++) begin
            line      <= 1'b1;
            disp_line <= n;
            @(posedge clk_sys);
            line <= 1'b0;
            repeat (blank_cycles) @(posedge clk_sys);  // row fill happens here
            for (c = 0; c < vis_cycles; c++) begin
                de       <= 1'b1;
                disp_col <= c;
                @(posedge clk_sys);
            end
            de <= 1'b0;
            repeat (gap_cycles) @(posedge clk_sys);
        end
    endtask

    // registered outputs compared against the inputs of one cycle earlier
    always @(negedge clk_sys) begin : check_outputs
        logic [11:0] exp_rgb;
        if (armed) begin
            if (prev_de) begin
                exp_rgb = palette_rgb(ref_mem[(prev_line/2)*fb_cols + prev_col/2]);
            end else begin
                exp_rgb = 12'h000;  // blanked
            end
            assert ({red, green, blue} == exp_rgb) else begin
                $display("FAIL %s rgb line %0d col %0d: expected %h actual %h",
                         test_name, prev_line, prev_col, exp_rgb, {red, green, blue});
                abort_run();
            end
            assert (clip == prev_clip) else begin
                $display("FAIL %s clip x %0d y %0d: expected %0b actual %0b",
                         test_name, prev_x, prev_y, prev_clip, clip);
                abort_run();
            end
        end
        prev_de   = de;
        prev_clip = exp_clip;
        prev_line = disp_line;
        prev_col  = disp_col;
        prev_x    = x;
        prev_y    = y;
    end

    initial begin : watchdog
        repeat (watchdog_cycles) @(posedge clk_sys);
        $display("watchdog: run did not finish within %0d cycles", watchdog_cycles);
        abort_run();
    end

    initial begin : stimulus
        int px;
        int py;
        int r;
        int i;
        clk_sys   = 1'b0;
        rst_sys   = 1'b1;
        we        = 1'b0;
        x         = '0;
        y         = '0;
        cidx      = '0;
        frame     = 1'b0;
        line      = 1'b0;
        de        = 1'b0;
        exp_clip  = 1'b0;
        disp_line = 0;
        disp_col  = 0;
        armed     = 1'b0;
        seed      = 20;
        test_name = "reset";
        repeat (2) @(posedge clk_sys);
        rst_sys <= 1'b0;
        armed = 1'b1;  // outputs already reset here
        idle_cycles(4);

        test_name = "draw";
        for (py = 0; py < fb_rows; py++) begin
            for (px = 0; px < fb_cols; px++) begin
                r = $random(seed);
                draw_pixel(px, py, r[3:0]);
            end
        end
        idle_cycles(4);

        // out of range writes that mostly wrap onto a valid pixel
        test_name = "clip";
        draw_pixel(16, 0, ~ref_mem[16]);          // wraps to (0,1)
        draw_pixel(-1, 1, ~ref_mem[15]);          // wraps to (15,0)
        draw_pixel(256, 0, ~ref_mem[0]);          // low byte zero
        draw_pixel(0, 16, ~ref_mem[0]);           // 16 rows wraps to 0
        draw_pixel(20, 3, ~ref_mem[68]);
        draw_pixel(-16, 5, ~ref_mem[64]);
        draw_pixel(5, -15, ~ref_mem[21]);
        draw_pixel(-32768, 0, ~ref_mem[0]);
        draw_pixel(32767, 11, ~ref_mem[175]);
        draw_pixel(0, 12, 4'h9);                  // just past last row
        draw_pixel(7, 6, 4'hc);                   // in range in between
        idle_cycles(4);

        test_name = "frame 1";
        run_frame();
        idle_cycles(4);

        // new colours land in the next frame only
        test_name = "overwrite";
        for (i = 0; i < 6; i++) begin
            r  = $random(seed);
            px = int'(r[3:0]);
            py = int'(r[11:4]) % fb_rows;
            draw_pixel(px, py, ~ref_mem[py*fb_cols + px]);
        end
        idle_cycles(4);

        test_name = "frame 2";
        run_frame();
        idle_cycles(4);

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire
